// File: vlog.f
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/game_fsm.sv
rtl/start_screen.sv
rtl/level_screen.sv
rtl/finish_screen.sv
rtl/screen_select.sv
rtl/game_top.sv
sim/game_tb.sv

// File: Bender.yml
package:
  name: game_display

sources:
  - files:
      - rtl/game_pkg.sv
      - rtl/vga_timing.sv
      - rtl/game_fsm.sv
      - rtl/start_screen.sv
      - rtl/level_screen.sv
      - rtl/finish_screen.sv
      - rtl/screen_select.sv
      - rtl/game_top.sv

  - target: simulation
    files:
      - sim/game_tb.sv

// File: sim/game_tb.sv
`timescale 1ns/10ps
`default_nettype none

module game_tb import game_pkg::*; ();

    // small raster so a frame takes a few thousand cycles
    localparam int H_ACTIVE    = 64;
    localparam int H_FP        = 4;
    localparam int H_SYNC      = 8;
    localparam int H_BP        = 4;
    localparam int V_ACTIVE    = 48;
    localparam int V_FP        = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BP        = 2;
    localparam int PLAYER_SIZE = 8;
    localparam int FLOOR_H     = 8;
    localparam int CHECK_LOG2  = 2;

    localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // sequence runs about five and a half frames and the limit allows nine
    localparam int TIMEOUT_CYCLES = 40000;
    localparam int ACK_WAIT       = 16;
    localparam int SEED           = 32'h3573_ee7e;

    logic        clk_40 = 1'b0;
    logic        rst;
    logic        state_req;
    logic        state_ack;
    game_state_t game_state;
    logic [11:0] xpos;
    logic [11:0] ypos;
    vga_sig_t    vga_out;

    // model of where the handshakes should have taken the game
    game_state_t exp_state;
    int          seed;
    int          cycle_cnt;
    int          reset_errs  = 0;
    int          raster_errs = 0;
    int          proto_errs  = 0;
    int          pixel_errs  = 0;

    // one-edge history of the sampled signals
    logic        prev_rst   = 1'b0;
    logic        prev_ack   = 1'b0;
    logic        prev_req   = 1'b0;
    game_state_t prev_state = START;
    vga_sig_t    prev_out   = '0;
    logic [11:0] x_d1       = '0;
    logic [11:0] x_d2       = '0;
    logic [11:0] y_d1       = '0;
    logic [11:0] y_d2       = '0;
    int          since_rst  = 0;
    logic        live;

    always #2 clk_40 = ~clk_40;

    game_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_FP        (H_FP),
        .H_SYNC      (H_SYNC),
        .H_BP        (H_BP),
        .V_ACTIVE    (V_ACTIVE),
        .V_FP        (V_FP),
        .V_SYNC      (V_SYNC),
        .V_BP        (V_BP),
        .PLAYER_SIZE (PLAYER_SIZE),
        .FLOOR_H     (FLOOR_H),
        .CHECK_LOG2  (CHECK_LOG2)
    ) u_game_top (
        .clk_40     (clk_40),
        .rst        (rst),
        .state_req  (state_req),
        .state_ack  (state_ack),
        .game_state (game_state),
        .xpos       (xpos),
        .ypos       (ypos),
        .vga_out    (vga_out)
    );

    always @(posedge clk_40) begin
        prev_rst   <= rst;
        prev_ack   <= state_ack;
        prev_req   <= state_req;
        prev_state <= game_state;
        prev_out   <= vga_out;
        x_d1       <= xpos;
        x_d2       <= x_d1;
        y_d1       <= ypos;
        y_d2       <= y_d1;
        // pipeline holds reset words for a few edges after release
        if (rst) begin
            since_rst <= 0;
        end else if (since_rst < 8) begin
            since_rst <= since_rst + 1;
        end
    end

    assign live = (since_rst >= 4);

    function automatic logic [10:0] next_hcount(logic [10:0] h);
        return (int'(h) == H_TOTAL - 1) ? 11'd0 : h + 11'd1;
    endfunction

    function automatic logic [10:0] next_vcount(logic [10:0] h, logic [10:0] v);
        if (int'(h) != H_TOTAL - 1) begin
            return v;
        end
        return (int'(v) == V_TOTAL - 1) ? 11'd0 : v + 11'd1;
    endfunction

    function automatic logic in_window(int pos, int lo, int len);
        return (pos >= lo) && (pos < lo + len);
    endfunction

    function automatic game_state_t next_screen(game_state_t s);
        case (s)
            START:   return LEVEL_1;
            LEVEL_1: return FINISH;
            default: return START;
        endcase
    endfunction

    // picture rules with blanking taken from the counts themselves
    function automatic logic [11:0] expected_rgb(game_state_t s, vga_sig_t w,
                                                 logic [11:0] x, logic [11:0] y);
        int h;
        int v;
        h = int'(w.hcount);
        v = int'(w.vcount);
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return 12'h000;
        end
        case (s)
            LEVEL_1: begin
                if (in_window(h, int'(x), PLAYER_SIZE) && in_window(v, int'(y), PLAYER_SIZE))
                    return COL_PLAYER;
                return (v >= V_ACTIVE - FLOOR_H) ? COL_FLOOR : COL_SKY;
            end
            FINISH: begin
                // cell parity along each axis
                if (((h >> CHECK_LOG2) & 1) != ((v >> CHECK_LOG2) & 1))
                    return COL_CHECK_A;
                return COL_CHECK_B;
            end
            default: begin
                if (in_window(h, H_ACTIVE / 4, H_ACTIVE / 2) &&
                    v >= V_ACTIVE / 3 && v < (2 * V_ACTIVE) / 3)
                    return COL_BUTTON;
                return COL_MENU_BG;
            end
        endcase
    endfunction

    // reset values hold on the first edge after release too
    assert property (@(posedge clk_40) prev_rst |-> vga_out == '0)
        else begin
            reset_errs++;
            $display("mismatch vga_out: got %h expected %h", $sampled(vga_out),
                     vga_sig_t'(0));
        end
    assert property (@(posedge clk_40) prev_rst |-> !state_ack)
        else begin
            reset_errs++;
            $display("mismatch state_ack: got %h expected %h", $sampled(state_ack), 1'b0);
        end
    assert property (@(posedge clk_40) prev_rst |-> game_state == START)
        else begin
            reset_errs++;
            $display("mismatch game_state: got %h expected %h", $sampled(game_state), START);
        end

    // raster counting against the previous word
    assert property (@(posedge clk_40) disable iff (rst)
        live |-> vga_out.hcount == next_hcount(prev_out.hcount))
        else begin
            raster_errs++;
            $display("mismatch vga_out.hcount: got %h expected %h", $sampled(vga_out.hcount),
                     next_hcount($sampled(prev_out.hcount)));
        end
    assert property (@(posedge clk_40) disable iff (rst)
        live |-> vga_out.vcount == next_vcount(prev_out.hcount, prev_out.vcount))
        else begin
            raster_errs++;
            $display("mismatch vga_out.vcount: got %h expected %h", $sampled(vga_out.vcount),
                     next_vcount($sampled(prev_out.hcount), $sampled(prev_out.vcount)));
        end

    // sync and blanking flags against the counts of the same word
    assert property (@(posedge clk_40) disable iff (rst) live |->
        vga_out.hsync == in_window(int'(vga_out.hcount), H_ACTIVE + H_FP, H_SYNC))
        else begin
            raster_errs++;
            $display("mismatch vga_out.hsync: got %h expected %h at hcount %h",
                     $sampled(vga_out.hsync),
                     in_window(int'($sampled(vga_out.hcount)), H_ACTIVE + H_FP, H_SYNC),
                     $sampled(vga_out.hcount));
        end
    assert property (@(posedge clk_40) disable iff (rst) live |->
        vga_out.hblnk == (int'(vga_out.hcount) >= H_ACTIVE))
        else begin
            raster_errs++;
            $display("mismatch vga_out.hblnk: got %h expected %h at hcount %h",
                     $sampled(vga_out.hblnk),
                     (int'($sampled(vga_out.hcount)) >= H_ACTIVE),
                     $sampled(vga_out.hcount));
        end
    assert property (@(posedge clk_40) disable iff (rst) live |->
        vga_out.vsync == in_window(int'(vga_out.vcount), V_ACTIVE + V_FP, V_SYNC))
        else begin
            raster_errs++;
            $display("mismatch vga_out.vsync: got %h expected %h at vcount %h",
                     $sampled(vga_out.vsync),
                     in_window(int'($sampled(vga_out.vcount)), V_ACTIVE + V_FP, V_SYNC),
                     $sampled(vga_out.vcount));
        end
    assert property (@(posedge clk_40) disable iff (rst) live |->
        vga_out.vblnk == (int'(vga_out.vcount) >= V_ACTIVE))
        else begin
            raster_errs++;
            $display("mismatch vga_out.vblnk: got %h expected %h at vcount %h",
                     $sampled(vga_out.vblnk),
                     (int'($sampled(vga_out.vcount)) >= V_ACTIVE),
                     $sampled(vga_out.vcount));
        end

    // four-phase handshake
    assert property (@(posedge clk_40) disable iff (rst)
        !prev_rst && state_ack && !prev_ack |-> prev_req)
        else begin
            proto_errs++;
            $display("state_ack rose although state_req was low");
        end
    assert property (@(posedge clk_40) disable iff (rst)
        !prev_rst && !state_ack && prev_ack |-> !prev_req)
        else begin
            proto_errs++;
            $display("state_ack fell although state_req was still high");
        end
    assert property (@(posedge clk_40) disable iff (rst)
        !prev_rst && game_state != prev_state |-> state_ack && !prev_ack)
        else begin
            proto_errs++;
            $display("game_state changed on an edge where state_ack did not rise");
        end
    assert property (@(posedge clk_40) disable iff (rst)
        !prev_rst && game_state != prev_state |-> game_state == next_screen(prev_state))
        else begin
            proto_errs++;
            $display("mismatch game_state: got %h expected %h", $sampled(game_state),
                     next_screen($sampled(prev_state)));
        end
    // outside the request phase the state must match the handshake count
    assert property (@(posedge clk_40) disable iff (rst)
        state_ack || !state_req |-> game_state == exp_state)
        else begin
            proto_errs++;
            $display("mismatch game_state: got %h expected %h",
                     $sampled(game_state), $sampled(exp_state));
        end

    // each word is picked by the state one edge back and drawn with the
    // player position two edges back
    assert property (@(posedge clk_40) disable iff (rst) live && prev_state != LEVEL_1 |->
        vga_out.rgb == expected_rgb(prev_state, vga_out, x_d2, y_d2))
        else begin
            pixel_errs++;
            $display("mismatch vga_out.rgb: got %h expected %h at h %h v %h",
                     $sampled(vga_out.rgb),
                     expected_rgb($sampled(prev_state), $sampled(vga_out), '0, '0),
                     $sampled(vga_out.hcount), $sampled(vga_out.vcount));
        end
    assert property (@(posedge clk_40) disable iff (rst) live && prev_state == LEVEL_1 |->
        vga_out.rgb == expected_rgb(LEVEL_1, vga_out, x_d2, y_d2))
        else begin
            pixel_errs++;
            $display("mismatch vga_out.rgb: got %h expected %h at h %h v %h",
                     $sampled(vga_out.rgb),
                     expected_rgb(LEVEL_1, $sampled(vga_out), $sampled(x_d2), $sampled(y_d2)),
                     $sampled(vga_out.hcount), $sampled(vga_out.vcount));
        end

    // inputs change 1 ns after the edge
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk_40);
        #1;
    endtask

    task automatic pick_position(input int x_lo, input int x_span,
                                 input int y_lo, input int y_span);
        int rnd;
        rnd  = $random(seed);
        xpos = 12'(x_lo + int'($unsigned(rnd) % x_span));
        rnd  = $random(seed);
        ypos = 12'(y_lo + int'($unsigned(rnd) % y_span));
    endtask

    // req held a few cycles past ack to show one step per handshake
    task automatic run_handshake(input int hold);
        int wait_cnt;
        exp_state = next_screen(exp_state);
        state_req = 1'b1;
        wait_cnt  = 0;
        while (!state_ack && wait_cnt < ACK_WAIT) begin
            step_cycles(1);
            wait_cnt++;
        end
        if (!state_ack) begin
            proto_errs++;
            $display("state_ack never rose after state_req was raised");
        end
        step_cycles(hold);
        state_req = 1'b0;
        wait_cnt  = 0;
        while (state_ack && wait_cnt < ACK_WAIT) begin
            step_cycles(1);
            wait_cnt++;
        end
        if (state_ack) begin
            proto_errs++;
            $display("state_ack stayed high after state_req was dropped");
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_40);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int total_errs;
        rst       = 1'b1;
        state_req = 1'b0;
        xpos      = '0;
        ypos      = '0;
        exp_state = START;
        seed      = SEED;
        step_cycles(5);
        rst = 1'b0;

        // menu
        step_cycles(FRAME_CYCLES);

        // level with the player anywhere on screen
        pick_position(0, H_ACTIVE, 0, V_ACTIVE);
        run_handshake(3);
        step_cycles(FRAME_CYCLES);
        // square hanging over the right edge
        pick_position(H_ACTIVE - PLAYER_SIZE + 1, PLAYER_SIZE - 1, 0, V_ACTIVE - FLOOR_H);
        step_cycles(FRAME_CYCLES);
        // square inside or across the floor band
        pick_position(0, H_ACTIVE, V_ACTIVE - FLOOR_H - 4, FLOOR_H + 4);
        step_cycles(FRAME_CYCLES);

        // checkerboard
        run_handshake(2);
        step_cycles(FRAME_CYCLES);

        // back to the menu
        run_handshake(4);
        step_cycles(FRAME_CYCLES / 2);

        total_errs = reset_errs + raster_errs + proto_errs + pixel_errs;
        $display("errors: reset %0d raster %0d handshake %0d pixel %0d total %0d",
                 reset_errs, raster_errs, proto_errs, pixel_errs, total_errs);
        if (total_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/game_top.sv
`timescale 1ns/10ps
`default_nettype none

module game_top import game_pkg::*; #(
    parameter int H_ACTIVE    = 800,
    parameter int H_FP        = 40,
    parameter int H_SYNC      = 128,
    parameter int H_BP        = 88,
    parameter int V_ACTIVE    = 600,
    parameter int V_FP        = 1,
    parameter int V_SYNC      = 4,
    parameter int V_BP        = 23,
    parameter int PLAYER_SIZE = 32,
    parameter int FLOOR_H     = 64,
    parameter int CHECK_LOG2  = 4
) (
    input  logic        clk_40,
    input  logic        rst,
    input  logic        state_req,
    output logic        state_ack,
    output game_state_t game_state,
    input  logic [11:0] xpos,
    input  logic [11:0] ypos,
    output vga_sig_t    vga_out
);

    // free running raster, rgb always zero here
    vga_sig_t raster;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) u_vga_timing (
        .clk_40 (clk_40),
        .rst    (rst),
        .raster (raster)
    );

    game_fsm u_game_fsm (
        .clk_40     (clk_40),
        .rst        (rst),
        .state_req  (state_req),
        .state_ack  (state_ack),
        .game_state (game_state)
    );

    // raster to vga_out is two cycles through renderer and selector
    screen_select #(
        .H_ACTIVE    (H_ACTIVE),
        .V_ACTIVE    (V_ACTIVE),
        .PLAYER_SIZE (PLAYER_SIZE),
        .FLOOR_H     (FLOOR_H),
        .CHECK_LOG2  (CHECK_LOG2)
    ) u_screen_select (
        .clk_40     (clk_40),
        .rst        (rst),
        .game_state (game_state),
        .xpos       (xpos),
        .ypos       (ypos),
        .vga_in     (raster),
        .vga_out    (vga_out)
    );

endmodule

`default_nettype wire

// File: rtl/screen_select.sv
`timescale 1ns/10ps
`default_nettype none

module screen_select import game_pkg::*; #(
    parameter int H_ACTIVE    = 800,
    parameter int V_ACTIVE    = 600,
    parameter int PLAYER_SIZE = 32,
    parameter int FLOOR_H     = 64,
    parameter int CHECK_LOG2  = 4
) (
    input  logic        clk_40,
    input  logic        rst,
    input  game_state_t game_state,
    input  logic [11:0] xpos,
    input  logic [11:0] ypos,
    input  vga_sig_t    vga_in,
    output vga_sig_t    vga_out
);

    // renderer outputs, all one stage behind vga_in
    vga_sig_t menu_pix;
    vga_sig_t level_pix;
    vga_sig_t finish_pix;
    vga_sig_t sel_pix;

    start_screen #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_start_screen (
        .clk_40  (clk_40),
        .rst     (rst),
        .vga_in  (vga_in),
        .vga_out (menu_pix)
    );

    level_screen #(
        .H_ACTIVE    (H_ACTIVE),
        .V_ACTIVE    (V_ACTIVE),
        .PLAYER_SIZE (PLAYER_SIZE),
        .FLOOR_H     (FLOOR_H)
    ) u_level_screen (
        .clk_40  (clk_40),
        .rst     (rst),
        .vga_in  (vga_in),
        .vga_out (level_pix),
        .xpos    (xpos),
        .ypos    (ypos)
    );

    finish_screen #(
        .CHECK_LOG2 (CHECK_LOG2)
    ) u_finish_screen (
        .clk_40  (clk_40),
        .rst     (rst),
        .vga_in  (vga_in),
        .vga_out (finish_pix)
    );

    // whole records are switched so timing and colour never mix
    always_comb begin
        case (game_state)
            START:   sel_pix = menu_pix;
            LEVEL_1: sel_pix = level_pix;
            FINISH:  sel_pix = finish_pix;
            default: sel_pix = menu_pix;
        endcase
    end

    // state change shows up one cycle after it happens
    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= sel_pix;
        end
    end

endmodule

`default_nettype wire

// File: rtl/finish_screen.sv
`timescale 1ns/10ps
`default_nettype none

module finish_screen import game_pkg::*; #(
    parameter int CHECK_LOG2 = 4
) (
    input  logic     clk_40,
    input  logic     rst,
    input  vga_sig_t vga_in,
    output vga_sig_t vga_out
);

    logic     col_bit;
    logic     row_bit;
    vga_sig_t pix_nxt;

    // cell index parity along each axis, cells are 2**CHECK_LOG2 wide
    assign col_bit = vga_in.hcount[CHECK_LOG2];
    assign row_bit = vga_in.vcount[CHECK_LOG2];

    always_comb begin
        pix_nxt = vga_in;
        if (vga_in.hblnk || vga_in.vblnk) begin
            pix_nxt.rgb = 12'h000;
        end else if (col_bit ^ row_bit) begin
            // odd cells light
            pix_nxt.rgb = COL_CHECK_A;
        end else begin
            pix_nxt.rgb = COL_CHECK_B;
        end
    end

    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= pix_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/level_screen.sv
`timescale 1ns/10ps
`default_nettype none

module level_screen import game_pkg::*; #(
    parameter int H_ACTIVE    = 800,
    parameter int V_ACTIVE    = 600,
    parameter int PLAYER_SIZE = 32,
    parameter int FLOOR_H     = 64
) (
    input  logic        clk_40,
    input  logic        rst,
    input  vga_sig_t    vga_in,
    output vga_sig_t    vga_out,
    input  logic [11:0] xpos,
    input  logic [11:0] ypos
);

    // first line of the floor band
    localparam int FLOOR_TOP = V_ACTIVE - FLOOR_H;

    logic [12:0] hpos;
    logic [12:0] vpos;
    logic [12:0] x_end;
    logic [12:0] y_end;
    logic        in_player;
    logic        in_floor;
    logic        blank;
    vga_sig_t    pix_nxt;

    // one extra bit so a square near the right or bottom edge
    // cannot wrap its far corner back to zero
    assign hpos  = {2'b00, vga_in.hcount};
    assign vpos  = {2'b00, vga_in.vcount};
    assign x_end = {1'b0, xpos} + 13'(PLAYER_SIZE);
    assign y_end = {1'b0, ypos} + 13'(PLAYER_SIZE);

    // square from xpos,ypos up to but not including the far edge
    assign in_player = (hpos >= {1'b0, xpos}) && (hpos < x_end)
                    && (vpos >= {1'b0, ypos}) && (vpos < y_end);

    assign in_floor = (vga_in.vcount >= 11'(FLOOR_TOP));
    assign blank    = vga_in.hblnk || vga_in.vblnk;

    // hidden wider than the visible area but only drawn while active
    always_comb begin
        pix_nxt = vga_in;
        if (blank) begin
            pix_nxt.rgb = 12'h000;
        end else if (in_player) begin
            // player is drawn over sky and floor alike
            pix_nxt.rgb = COL_PLAYER;
        end else if (in_floor) begin
            pix_nxt.rgb = COL_FLOOR;
        end else begin
            pix_nxt.rgb = COL_SKY;
        end
    end

    // xpos and ypos come from the same clock domain and are sampled here directly
    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= pix_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/start_screen.sv
`timescale 1ns/10ps
`default_nettype none

module start_screen import game_pkg::*; #(
    parameter int H_ACTIVE = 800,
    parameter int V_ACTIVE = 600
) (
    input  logic     clk_40,
    input  logic     rst,
    input  vga_sig_t vga_in,
    output vga_sig_t vga_out
);

    // button occupies the middle half across and the middle third down
    localparam int BTN_X0 = H_ACTIVE / 4;
    localparam int BTN_X1 = (3 * H_ACTIVE) / 4;
    localparam int BTN_Y0 = V_ACTIVE / 3;
    localparam int BTN_Y1 = (2 * V_ACTIVE) / 3;

    logic     in_button;
    vga_sig_t pix_nxt;

    assign in_button = (vga_in.hcount >= 11'(BTN_X0)) && (vga_in.hcount < 11'(BTN_X1))
                    && (vga_in.vcount >= 11'(BTN_Y0)) && (vga_in.vcount < 11'(BTN_Y1));

    always_comb begin
        // timing fields ride along untouched
        pix_nxt = vga_in;
        if (vga_in.hblnk || vga_in.vblnk) begin
            // black outside the visible area
            pix_nxt.rgb = 12'h000;
        end else if (in_button) begin
            pix_nxt.rgb = COL_BUTTON;
        end else begin
            pix_nxt.rgb = COL_MENU_BG;
        end
    end

    // single stage keeps rgb aligned with its own counts
    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= pix_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/game_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module game_fsm import game_pkg::*; (
    input  logic        clk_40,
    input  logic        rst,
    input  logic        state_req,
    output logic        state_ack,
    output game_state_t game_state
);

    game_state_t state_nxt;

    // fixed screen order, wraps back to the menu
    always_comb begin
        case (game_state)
            START:   state_nxt = LEVEL_1;
            LEVEL_1: state_nxt = FINISH;
            FINISH:  state_nxt = START;
            default: state_nxt = START;
        endcase
    end

    // four-phase responder
    // idle      ack low, waiting for req
    // accepted  req seen high, state steps and ack rises together
    // release   ack held until req drops, then ack falls
    always_ff @(posedge clk_40) begin
        if (rst) begin
            game_state <= START;
            state_ack  <= 1'b0;
        end else begin
            if (!state_ack && state_req) begin
                // one step per handshake
                game_state <= state_nxt;
                state_ack  <= 1'b1;
            end else if (state_ack && !state_req) begin
                state_ack  <= 1'b0;
            end
            // a req still high after ack falls is a fresh request only
            // once it has been seen low, which the ack phase guarantees
        end
    end

endmodule

`default_nettype wire

// File: rtl/vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vga_timing import game_pkg::*; #(
    parameter int H_ACTIVE = 800,
    parameter int H_FP     = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BP     = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BP     = 23
) (
    input  logic     clk_40,
    input  logic     rst,
    output vga_sig_t raster
);

    // full line and frame lengths
    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

    // sync pulse windows, start inclusive and end exclusive
    localparam int H_SYNC_START = H_ACTIVE + H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    logic [10:0] h_next;
    logic [10:0] v_next;
    logic        h_wrap;
    vga_sig_t    raster_nxt;

    // the output register doubles as the counter pair
    assign h_wrap = (raster.hcount == 11'(H_TOTAL - 1));

    always_comb begin
        h_next = h_wrap ? 11'd0 : raster.hcount + 11'd1;
        v_next = raster.vcount;
        // new line only when the pixel counter rolls over
        if (h_wrap) begin
            if (raster.vcount == 11'(V_TOTAL - 1)) begin
                v_next = 11'd0;
            end else begin
                v_next = raster.vcount + 11'd1;
            end
        end
    end

    // flags are decoded from the next counts so that they land
    // in the same word as the counts they describe
    always_comb begin
        raster_nxt.hcount = h_next;
        raster_nxt.vcount = v_next;
        raster_nxt.hsync  = (h_next >= 11'(H_SYNC_START)) && (h_next < 11'(H_SYNC_END));
        raster_nxt.hblnk  = (h_next >= 11'(H_ACTIVE));
        raster_nxt.vsync  = (v_next >= 11'(V_SYNC_START)) && (v_next < 11'(V_SYNC_END));
        raster_nxt.vblnk  = (v_next >= 11'(V_ACTIVE));
        // timing carries no picture
        raster_nxt.rgb    = 12'h000;
    end

    always_ff @(posedge clk_40) begin
        if (rst) begin
            // position 0,0 lies in the active area, so all flags low
            raster <= '0;
        end else begin
            raster <= raster_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/game_pkg.sv
`default_nettype none

package game_pkg;

    // one raster position and the pixel drawn there
    // field order follows the bus layout used across the display chain
    typedef struct packed {
        logic [10:0] vcount;
        logic        vsync;
        logic        vblnk;
        logic [10:0] hcount;
        logic        hsync;
        logic        hblnk;
        logic [11:0] rgb;
    } vga_sig_t;

    // screens in the order the handshake walks through them
    typedef enum logic [1:0] {
        START   = 2'd0,
        LEVEL_1 = 2'd1,
        FINISH  = 2'd2
    } game_state_t;

    // 4:4:4 colours, r in the top nibble
    // start menu
    localparam logic [11:0] COL_MENU_BG = 12'h115;
    localparam logic [11:0] COL_BUTTON  = 12'hfa0;

    // level
    localparam logic [11:0] COL_SKY     = 12'h6af;
    localparam logic [11:0] COL_FLOOR   = 12'h740;
    localparam logic [11:0] COL_PLAYER  = 12'hf00;

    // finish checkerboard
    localparam logic [11:0] COL_CHECK_A = 12'hfff;
    localparam logic [11:0] COL_CHECK_B = 12'h000;

endpackage

`default_nettype wire
